//--- hdl/bram_pkg.sv
package bram_pkg;

  // axi4-lite side of the memory subsystem
  typedef logic [11:0] axil_addr_t;  // byte address, 4 KiB window
  typedef logic [31:0] axil_data_t;  // one bus word
  typedef logic [3:0]  axil_strb_t;  // one strobe per byte lane
  typedef logic [1:0]  axil_resp_t;  // bresp / rresp encoding

  // response codes used by the slave
  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_DECERR = 2'b11;  // nothing mapped at that address

  // wide bram port, same width as the axi data bus
  localparam int IN_WIDTH = 32;

  // default bank geometry, overridden from the top level
  // a bank holds one datum per row, several data share one wide word
  localparam int DEF_OUT_WIDTH  = 16;   // bits per bank datum: 8, 16 or 32
  localparam int DEF_BANKS      = 4;    // power of two, >= data per wide word
  localparam int DEF_OUT_DEPTH  = 256;  // rows per bank, power of two
  localparam int DEF_RD_LATENCY = 1;    // bank read pipeline depth

  // with the defaults
  //   data per wide word : 32 / 16 = 2
  //   wide words         : 4 * 256 / 2 = 512
  //   mapped bytes       : 512 * 4 = 0x800
  // anything from 0x800 up answers decerr

  // datum j of wide word a sits in bank (a*n + j) % BANKS,
  // at row (a*n + j) / BANKS, n being the data per wide word
  // so neighbouring data always land in neighbouring banks
  // and one wide access never hits the same bank twice

  // lowest datum travels in the lowest bits of the wide word,
  // its byte strobes go along with it

  // the sizes derived from these numbers
  // (data per word, depths, address widths) are worked out
  // inside each module with $clog2

endpackage

//--- hdl/bram_if.sv
`timescale 1ns/1ps

// single-port bram request bundle
// a request is one cycle with en high, we all zero means read
// read data show up RD_LATENCY cycles later on rddata
interface bram_if #(
  parameter int DATA_W = 32,  // data bits, multiple of 8
  parameter int ADDR_W = 9    // word address bits
) ();

  logic                en;      // request strobe
  logic [DATA_W/8-1:0] we;      // byte write enables
  logic [ADDR_W-1:0]   addr;    // word address
  logic [DATA_W-1:0]   wrdata;  // write payload
  logic [DATA_W-1:0]   rddata;  // read return, valid for one cycle

  // requester side, controller or translator
  modport ctrl (
    output en, we, addr, wrdata,
    input  rddata
  );

  // memory side, translator or bank
  modport mem (
    input  en, we, addr, wrdata,
    output rddata
  );

endinterface

//--- hdl/axil_bram_ctrl.sv
`timescale 1ns/1ps

// axi4-lite slave in front of one wide bram port
// one transaction in flight, a write beats a read in the same cycle
module axil_bram_ctrl #(
  parameter int DEPTH_WORDS = 512,  // wide words behind the port
  parameter int RD_LATENCY  = 1     // bram read latency in cycles
) (
  input  logic                 clk,
  input  logic                 reset_i,
  // write address and data
  input  bram_pkg::axil_addr_t s_awaddr_i,
  input  logic                 s_awvalid_i,
  output logic                 s_awready_o,
  input  bram_pkg::axil_data_t s_wdata_i,
  input  bram_pkg::axil_strb_t s_wstrb_i,
  input  logic                 s_wvalid_i,
  output logic                 s_wready_o,
  // write response
  output bram_pkg::axil_resp_t s_bresp_o,
  output logic                 s_bvalid_o,
  input  logic                 s_bready_i,
  // read address
  input  bram_pkg::axil_addr_t s_araddr_i,
  input  logic                 s_arvalid_i,
  output logic                 s_arready_o,
  // read data
  output bram_pkg::axil_data_t s_rdata_o,
  output bram_pkg::axil_resp_t s_rresp_o,
  output logic                 s_rvalid_o,
  input  logic                 s_rready_i,
  bram_if.ctrl                 bram         // wide request port
);

  localparam int ADDR_W = $clog2(DEPTH_WORDS);     // wide word address bits
  localparam int CNT_W  = $clog2(RD_LATENCY + 1);  // never zero wide
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(RD_LATENCY - 1);

  typedef enum logic [2:0] {
    IDLE,     // waiting for aw+w or ar
    WR_REQ,   // bram write strobe
    WR_RESP,  // bvalid up
    RD_REQ,   // bram read strobe
    RD_WAIT,  // bram read pipeline in flight
    RD_RESP   // rvalid up
  } state_t;

  state_t               state_q;
  logic [CNT_W-1:0]     lat_cnt_q;  // cycles spent in RD_WAIT
  bram_pkg::axil_addr_t addr_q;     // byte address of the current transfer
  bram_pkg::axil_data_t wdata_q;
  bram_pkg::axil_strb_t wstrb_q;
  bram_pkg::axil_data_t rdata_q;    // read response payload
  logic                 addr_ok;    // word lies inside the banks
  logic                 wr_go;
  logic                 rd_go;
  logic                 rd_done;    // last RD_WAIT cycle, rddata valid now

  // handshakes, only taken from IDLE so no response can be pending
  assign wr_go = (state_q == IDLE) && s_awvalid_i && s_wvalid_i;
  assign rd_go = (state_q == IDLE) && s_arvalid_i && !wr_go;  // write wins

  assign s_awready_o = wr_go;  // aw and w go together
  assign s_wready_o  = wr_go;
  assign s_arready_o = rd_go;

  // byte address bits 11:2 form the word index
  assign addr_ok = (int'(addr_q[11:2]) < DEPTH_WORDS);
  assign rd_done = (state_q == RD_WAIT) && (lat_cnt_q == LAST_CNT);

  // out-of-range transfers walk the same states with en kept low
  assign bram.en     = ((state_q == WR_REQ) || (state_q == RD_REQ)) && addr_ok;
  assign bram.we     = (state_q == WR_REQ) ? wstrb_q : '0;  // zero marks a read
  assign bram.addr   = addr_q[ADDR_W+1:2];
  assign bram.wrdata = wdata_q;

  // response channels straight from the state and the latched payload
  assign s_bvalid_o = (state_q == WR_RESP);
  assign s_bresp_o  = addr_ok ? bram_pkg::RESP_OKAY : bram_pkg::RESP_DECERR;
  assign s_rvalid_o = (state_q == RD_RESP);
  assign s_rresp_o  = addr_ok ? bram_pkg::RESP_OKAY : bram_pkg::RESP_DECERR;
  assign s_rdata_o  = rdata_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q   <= IDLE;
      lat_cnt_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (wr_go) begin
            state_q <= WR_REQ;
          end else if (rd_go) begin
            state_q <= RD_REQ;
          end
        end
        WR_REQ:  state_q <= WR_RESP;  // write lands this edge
        WR_RESP: begin
          if (s_bready_i) state_q <= IDLE;
        end
        RD_REQ: begin
          lat_cnt_q <= '0;
          state_q   <= RD_WAIT;
        end
        RD_WAIT: begin
          if (rd_done) begin
            state_q <= RD_RESP;
          end else begin
            lat_cnt_q <= lat_cnt_q + 1'b1;
          end
        end
        RD_RESP: begin
          if (s_rready_i) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // payload latches
  always_ff @(posedge clk) begin
    if (wr_go) begin
      addr_q  <= s_awaddr_i;
      wdata_q <= s_wdata_i;
      wstrb_q <= s_wstrb_i;
    end else if (rd_go) begin
      addr_q <= s_araddr_i;
    end
    if (rd_done) begin
      rdata_q <= addr_ok ? bram.rddata : '0;  // decerr returns zero data
    end
  end

  // b channel holds valid and response until bready
  ap_b_hold: assert property (@(posedge clk) disable iff (reset_i)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));

  // r channel holds valid and payload until rready
  ap_r_hold: assert property (@(posedge clk) disable iff (reset_i)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o));

  // no bram traffic while idle
  ap_idle_quiet: assert property (@(posedge clk) disable iff (reset_i)
    (state_q == IDLE) |-> !bram.en);

endmodule

//--- hdl/bank_xlate.sv
`timescale 1ns/1ps

// fans one wide bram request out to the banks, one datum per bank,
// and stitches the wide read word back together
module bank_xlate #(
  parameter int OUT_WIDTH  = 16,   // bits per bank datum
  parameter int BANKS      = 4,    // power of two
  parameter int OUT_DEPTH  = 256,  // rows per bank
  parameter int RD_LATENCY = 1     // bank read latency
) (
  input logic  clk,
  bram_if.mem  wide,           // wide request from the controller
  bram_if.ctrl banks [BANKS]   // narrow port per bank
);

  localparam int IN_WORD_DATA = bram_pkg::IN_WIDTH / OUT_WIDTH;  // data per wide word
  localparam int OUT_WE       = OUT_WIDTH / 8;                   // strobes per datum
  localparam int IN_DEPTH     = BANKS * OUT_DEPTH / IN_WORD_DATA;
  localparam int IN_ADDR      = $clog2(IN_DEPTH);
  localparam int OUT_ADDR     = $clog2(OUT_DEPTH);
  localparam int INJ_BITS     = $clog2(IN_WORD_DATA);  // datum index under the word address
  localparam int BANK_BITS    = $clog2(BANKS);
  localparam int LIN_ADDR     = IN_ADDR + INJ_BITS;    // flat datum address, = bank + row

  typedef logic [BANK_BITS-1:0] bank_idx_t;
  typedef logic [LIN_ADDR-1:0]  lin_addr_t;

  lin_addr_t                   lin_addr [IN_WORD_DATA];  // flat address of each datum
  bank_idx_t                   tgt_bank [IN_WORD_DATA];  // bank hit by each datum
  bank_idx_t                   tgt_pipe [RD_LATENCY][IN_WORD_DATA];
  logic [OUT_WIDTH-1:0]        bank_rd  [BANKS];         // read data gathered from the banks
  logic [BANKS-1:0]            bank_en;
  logic [bram_pkg::IN_WIDTH-1:0] rd_word;

  // datum j of word a -> flat index a*IN_WORD_DATA + j
  // low bits of that pick the bank, the rest is the row
  always_comb begin
    for (int j = 0; j < IN_WORD_DATA; j++) begin
      lin_addr[j] = {wide.addr, INJ_BITS'(j)};
      tgt_bank[j] = lin_addr[j][BANK_BITS-1:0];
    end
  end

  // bank b can only ever see datum b % IN_WORD_DATA,
  // it is enabled when that datum actually maps onto it
  for (genvar b = 0; b < BANKS; b++) begin : g_bank
    localparam int J = b % IN_WORD_DATA;

    assign bank_en[b]      = wide.en && (tgt_bank[J] == BANK_BITS'(b));
    assign banks[b].en     = bank_en[b];
    assign banks[b].we     = wide.we[J*OUT_WE +: OUT_WE];  // strobes follow the datum
    assign banks[b].addr   = lin_addr[J][BANK_BITS +: OUT_ADDR];
    assign banks[b].wrdata = wide.wrdata[J*OUT_WIDTH +: OUT_WIDTH];
    assign bank_rd[b]      = banks[b].rddata;
  end

  // bank indices ride along with the read, RD_LATENCY stages
  always_ff @(posedge clk) begin
    tgt_pipe[0] <= tgt_bank;
    for (int s = 1; s < RD_LATENCY; s++) begin
      tgt_pipe[s] <= tgt_pipe[s-1];
    end
  end

  // lowest datum into the lowest bits
  always_comb begin
    for (int j = 0; j < IN_WORD_DATA; j++) begin
      rd_word[j*OUT_WIDTH +: OUT_WIDTH] = bank_rd[tgt_pipe[RD_LATENCY-1][j]];
    end
  end

  assign wide.rddata = rd_word;

  // each wide access touches exactly one bank per datum
  ap_bank_fanout: assert property (@(posedge clk)
    wide.en |-> ($countones(bank_en) == IN_WORD_DATA));

endmodule

//--- hdl/bram_bank.sv
`timescale 1ns/1ps

// one narrow bank, byte write enables, pipelined read
module bram_bank #(
  parameter int OUT_WIDTH  = 16,   // row width, multiple of 8
  parameter int OUT_DEPTH  = 256,  // rows
  parameter int RD_LATENCY = 1     // read pipeline stages, >= 1
) (
  input logic clk,
  bram_if.mem port_if
);

  localparam int OUT_WE = OUT_WIDTH / 8;  // byte lanes per row

  logic [OUT_WIDTH-1:0] mem_q   [OUT_DEPTH];   // storage, contents undefined after power-up
  logic [OUT_WIDTH-1:0] rd_pipe [RD_LATENCY];  // read output stages
  logic                 rd_req;

  // request with no strobes set is a read
  assign rd_req = port_if.en && (port_if.we == '0);

  // byte-wise write at the request edge
  always_ff @(posedge clk) begin
    if (port_if.en) begin
      for (int k = 0; k < OUT_WE; k++) begin
        if (port_if.we[k]) begin
          mem_q[port_if.addr][k*8 +: 8] <= port_if.wrdata[k*8 +: 8];
        end
      end
    end
  end

  // first stage loads the row, later stages just shift
  always_ff @(posedge clk) begin
    if (rd_req) begin
      rd_pipe[0] <= mem_q[port_if.addr];
    end
    for (int s = 1; s < RD_LATENCY; s++) begin
      rd_pipe[s] <= rd_pipe[s-1];
    end
  end

  assign port_if.rddata = rd_pipe[RD_LATENCY-1];  // RD_LATENCY cycles after the request

endmodule

//--- hdl/banked_mem_top.sv
`timescale 1ns/1ps

// axi4-lite memory built from interleaved narrow banks
// controller -> translator -> BANKS banks
module banked_mem_top #(
  parameter int OUT_WIDTH  = bram_pkg::DEF_OUT_WIDTH,   // bank datum width
  parameter int BANKS      = bram_pkg::DEF_BANKS,       // bank count
  parameter int OUT_DEPTH  = bram_pkg::DEF_OUT_DEPTH,   // rows per bank
  parameter int RD_LATENCY = bram_pkg::DEF_RD_LATENCY   // bank read latency
) (
  input  logic                 clk,
  input  logic                 reset_i,
  // write channels
  input  bram_pkg::axil_addr_t s_awaddr_i,
  input  logic                 s_awvalid_i,
  output logic                 s_awready_o,
  input  bram_pkg::axil_data_t s_wdata_i,
  input  bram_pkg::axil_strb_t s_wstrb_i,
  input  logic                 s_wvalid_i,
  output logic                 s_wready_o,
  output bram_pkg::axil_resp_t s_bresp_o,
  output logic                 s_bvalid_o,
  input  logic                 s_bready_i,
  // read channels
  input  bram_pkg::axil_addr_t s_araddr_i,
  input  logic                 s_arvalid_i,
  output logic                 s_arready_o,
  output bram_pkg::axil_data_t s_rdata_o,
  output bram_pkg::axil_resp_t s_rresp_o,
  output logic                 s_rvalid_o,
  input  logic                 s_rready_i
);

  localparam int IN_WORD_DATA = bram_pkg::IN_WIDTH / OUT_WIDTH;
  localparam int DEPTH_WORDS  = BANKS * OUT_DEPTH / IN_WORD_DATA;  // wide words in total
  localparam int IN_ADDR      = $clog2(DEPTH_WORDS);
  localparam int OUT_ADDR     = $clog2(OUT_DEPTH);

  // geometry must fit the interleave and the 4 KiB window
  if (BANKS < IN_WORD_DATA) begin : g_chk_banks
    $error("BANKS must be at least the data per wide word");
  end
  if (DEPTH_WORDS * 4 > 4096) begin : g_chk_span
    $error("memory does not fit the 12-bit axi address space");
  end

  bram_if #(.DATA_W(bram_pkg::IN_WIDTH), .ADDR_W(IN_ADDR)) wide_if ();       // ctrl -> xlate
  bram_if #(.DATA_W(OUT_WIDTH), .ADDR_W(OUT_ADDR))         bank_if [BANKS] (); // xlate -> banks

  axil_bram_ctrl #(
    .DEPTH_WORDS (DEPTH_WORDS),
    .RD_LATENCY  (RD_LATENCY)
  ) u_ctrl (
    .clk         (clk),
    .reset_i     (reset_i),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wstrb_i   (s_wstrb_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .bram        (wide_if)
  );

  bank_xlate #(
    .OUT_WIDTH  (OUT_WIDTH),
    .BANKS      (BANKS),
    .OUT_DEPTH  (OUT_DEPTH),
    .RD_LATENCY (RD_LATENCY)
  ) u_xlate (
    .clk   (clk),
    .wide  (wide_if),
    .banks (bank_if)
  );

  // one bank per narrow port
  for (genvar b = 0; b < BANKS; b++) begin : g_banks
    bram_bank #(
      .OUT_WIDTH  (OUT_WIDTH),
      .OUT_DEPTH  (OUT_DEPTH),
      .RD_LATENCY (RD_LATENCY)
    ) u_bank (
      .clk     (clk),
      .port_if (bank_if[b])
    );
  end

endmodule

//--- dv/tb_banked_mem.sv
`timescale 1ns/1ps

// random axi4-lite traffic against banked_mem_top, checked against a byte model
module tb_banked_mem;

  // mapped bytes with the default geometry, 0x800
  localparam int MEM_BYTES = bram_pkg::DEF_BANKS * bram_pkg::DEF_OUT_DEPTH
                             * bram_pkg::DEF_OUT_WIDTH / 8;
  localparam int TIMEOUT_CYC = 200;  // per wait loop

  logic                 clk;
  logic                 reset_i;
  bram_pkg::axil_addr_t s_awaddr_i;
  logic                 s_awvalid_i;
  logic                 s_awready_o;
  bram_pkg::axil_data_t s_wdata_i;
  bram_pkg::axil_strb_t s_wstrb_i;
  logic                 s_wvalid_i;
  logic                 s_wready_o;
  bram_pkg::axil_resp_t s_bresp_o;
  logic                 s_bvalid_o;
  logic                 s_bready_i;
  bram_pkg::axil_addr_t s_araddr_i;
  logic                 s_arvalid_i;
  logic                 s_arready_o;
  bram_pkg::axil_data_t s_rdata_o;
  bram_pkg::axil_resp_t s_rresp_o;
  logic                 s_rvalid_o;
  logic                 s_rready_i;

  logic [7:0]           model_mem [bram_pkg::axil_addr_t];  // only bytes ever written
  bram_pkg::axil_addr_t used_addr [$];                      // in-range words written so far
  string                test_name;
  bit                   stall_en;  // random bready / rready

  banked_mem_top u_banked_mem_top (
    .clk         (clk),
    .reset_i     (reset_i),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wstrb_i   (s_wstrb_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // byte-wise, unwritten lanes are masked off
  task automatic check_data(input string what, input bram_pkg::axil_data_t exp,
                            input bram_pkg::axil_data_t act, input bram_pkg::axil_strb_t mask);
    for (int k = 0; k < 4; k++) begin
      if (mask[k] && (exp[k*8 +: 8] !== act[k*8 +: 8])) begin
        stop_on_error($sformatf("** Error %s %s: expected %h, actual %h (lanes %b)",
                                test_name, what, exp, act, mask));
      end
    end
  endtask

  task automatic check_resp(input string what, input bram_pkg::axil_resp_t exp,
                            input bram_pkg::axil_resp_t act);
    if (exp !== act) begin
      stop_on_error($sformatf("** Error %s %s: expected %h, actual %h",
                              test_name, what, exp, act));
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      stop_on_error($sformatf("** Error %s %s: expected %b, actual %b",
                              test_name, what, exp, act));
    end
  endtask

  task automatic next_slot();  // inputs change 1 ns after the edge
    @(posedge clk);
    #1;
  endtask

  function automatic logic pick_ready();
    return stall_en ? 1'($urandom % 2) : 1'b1;
  endfunction

  task automatic axil_write(input bram_pkg::axil_addr_t addr, input bram_pkg::axil_data_t data,
                            input bram_pkg::axil_strb_t strb, output bram_pkg::axil_resp_t resp);
    int                   cnt;
    bit                   seen;
    bit                   done;
    bram_pkg::axil_resp_t held;
    s_awaddr_i  = addr;
    s_awvalid_i = 1'b1;
    s_wdata_i   = data;
    s_wstrb_i   = strb;
    s_wvalid_i  = 1'b1;
    cnt = 0;
    @(negedge clk);  // ready is settled mid-cycle
    while (!s_awready_o) begin
      cnt++;
      if (cnt > TIMEOUT_CYC) stop_on_error("timeout: write address was never accepted");
      @(negedge clk);
    end
    check_flag("wready with awready", 1'b1, s_wready_o);
    next_slot();  // handshake edge passed
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = pick_ready();
    cnt  = 0;
    seen = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (s_bvalid_o) begin
        if (seen) check_resp("bresp held", held, s_bresp_o);
        held = s_bresp_o;
        seen = 1'b1;
        done = s_bready_i;
      end else if (seen) begin
        stop_on_error("bvalid dropped before bready was given");
      end
      cnt++;
      if (cnt > TIMEOUT_CYC) stop_on_error("timeout: no write response");
      if (!done) begin
        next_slot();
        s_bready_i = pick_ready();  // stall pattern changes every cycle
      end
    end
    resp = held;
    next_slot();
    s_bready_i = 1'b0;
  endtask

  task automatic axil_read(input bram_pkg::axil_addr_t addr, output bram_pkg::axil_data_t data,
                           output bram_pkg::axil_resp_t resp);
    int                   cnt;
    bit                   seen;
    bit                   done;
    bram_pkg::axil_data_t held_d;
    bram_pkg::axil_resp_t held_r;
    s_araddr_i  = addr;
    s_arvalid_i = 1'b1;
    cnt = 0;
    @(negedge clk);
    while (!s_arready_o) begin  // may sit behind a write
      cnt++;
      if (cnt > TIMEOUT_CYC) stop_on_error("timeout: read address was never accepted");
      @(negedge clk);
    end
    next_slot();
    s_arvalid_i = 1'b0;
    s_rready_i  = pick_ready();
    cnt  = 0;
    seen = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (s_rvalid_o) begin
        if (seen) begin
          check_data("rdata held", held_d, s_rdata_o, 4'hf);
          check_resp("rresp held", held_r, s_rresp_o);
        end
        held_d = s_rdata_o;
        held_r = s_rresp_o;
        seen   = 1'b1;
        done   = s_rready_i;
      end else if (seen) begin
        stop_on_error("rvalid dropped before rready was given");
      end
      cnt++;
      if (cnt > TIMEOUT_CYC) stop_on_error("timeout: no read data");
      if (!done) begin
        next_slot();
        s_rready_i = pick_ready();
      end
    end
    data = held_d;
    resp = held_r;
    next_slot();
    s_rready_i = 1'b0;
  endtask

  // model update, one byte per strobe
  task automatic apply_write(input bram_pkg::axil_addr_t addr, input bram_pkg::axil_data_t data,
                             input bram_pkg::axil_strb_t strb);
    for (int k = 0; k < 4; k++) begin
      if (strb[k]) model_mem[addr + bram_pkg::axil_addr_t'(k)] = data[k*8 +: 8];
    end
  endtask

  task automatic expect_word(input bram_pkg::axil_addr_t addr, output bram_pkg::axil_data_t data,
                             output bram_pkg::axil_strb_t mask);
    bram_pkg::axil_addr_t a;
    data = '0;
    mask = '0;
    for (int k = 0; k < 4; k++) begin
      a = addr + bram_pkg::axil_addr_t'(k);
      if (model_mem.exists(a)) begin
        data[k*8 +: 8] = model_mem[a];
        mask[k]        = 1'b1;
      end
    end
  endtask

  task automatic write_and_check(input bram_pkg::axil_addr_t addr,
                                 input bram_pkg::axil_data_t data, input bram_pkg::axil_strb_t strb);
    bram_pkg::axil_resp_t resp;
    bit                   in_range;
    in_range = (int'(addr) < MEM_BYTES);
    axil_write(addr, data, strb, resp);
    check_resp($sformatf("bresp @%h", addr),
               in_range ? bram_pkg::RESP_OKAY : bram_pkg::RESP_DECERR, resp);
    if (in_range) apply_write(addr, data, strb);  // decerr leaves memory alone
  endtask

  task automatic read_and_check(input bram_pkg::axil_addr_t addr);
    bram_pkg::axil_data_t data;
    bram_pkg::axil_resp_t resp;
    bram_pkg::axil_data_t exp;
    bram_pkg::axil_strb_t mask;
    bit                   in_range;
    in_range = (int'(addr) < MEM_BYTES);
    axil_read(addr, data, resp);
    check_resp($sformatf("rresp @%h", addr),
               in_range ? bram_pkg::RESP_OKAY : bram_pkg::RESP_DECERR, resp);
    expect_word(addr, exp, mask);  // model read after the fact, no same-word overlap
    if (in_range) check_data($sformatf("rdata @%h", addr), exp, data, mask);
  endtask

  function automatic bram_pkg::axil_addr_t rand_word_addr();
    return bram_pkg::axil_addr_t'(($urandom % (MEM_BYTES / 4)) * 4);
  endfunction

  function automatic bram_pkg::axil_addr_t rand_high_addr();  // unmapped window
    return bram_pkg::axil_addr_t'(MEM_BYTES + ($urandom % ((4096 - MEM_BYTES) / 4)) * 4);
  endfunction

  function automatic bram_pkg::axil_addr_t pick_addr();  // half old words, half fresh
    if ($urandom % 2) return used_addr[$urandom % used_addr.size()];
    return rand_word_addr();
  endfunction

  // one random read or write, the odd one out of range
  task automatic random_op();
    bram_pkg::axil_addr_t a;
    a = ($urandom % 10 == 0) ? rand_high_addr() : pick_addr();
    if ($urandom % 2) begin
      write_and_check(a, $urandom, bram_pkg::axil_strb_t'($urandom % 16));
    end else begin
      read_and_check(a);
    end
  endtask

  initial begin
    bram_pkg::axil_addr_t wa;
    bram_pkg::axil_addr_t ra;
    bram_pkg::axil_data_t wd;
    bram_pkg::axil_strb_t ws;
    void'($urandom(32'hec9d_32c8));
    stall_en    = 1'b0;
    test_name   = "reset";
    reset_i     = 1'b1;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = '0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset_i = 1'b0;
    @(negedge clk);
    check_flag("awready", 1'b0, s_awready_o);
    check_flag("wready", 1'b0, s_wready_o);
    check_flag("arready", 1'b0, s_arready_o);
    check_flag("bvalid", 1'b0, s_bvalid_o);
    check_flag("rvalid", 1'b0, s_rvalid_o);
    next_slot();

    test_name = "full strobe";
    repeat (200) begin
      wa = rand_word_addr();
      used_addr.push_back(wa);
      write_and_check(wa, $urandom, 4'hf);
    end
    foreach (used_addr[i]) begin  // neighbours catch bank or row mix-ups
      read_and_check(used_addr[i]);
      if (used_addr[i] >= 4) read_and_check(used_addr[i] - 12'd4);
      if (int'(used_addr[i]) + 4 < MEM_BYTES) read_and_check(used_addr[i] + 12'd4);
    end

    test_name = "partial strobe";
    repeat (150) begin
      wa = used_addr[$urandom % used_addr.size()];
      write_and_check(wa, $urandom, bram_pkg::axil_strb_t'(($urandom % 15) + 1));
      read_and_check(wa);
    end

    test_name = "out of range";
    repeat (40) begin
      wa = rand_high_addr();
      write_and_check(wa, $urandom, 4'hf);
      read_and_check(wa);
    end
    foreach (used_addr[i]) read_and_check(used_addr[i]);  // nothing may have moved

    test_name = "back-pressure";
    stall_en = 1'b1;
    repeat (150) random_op();

    test_name = "mixed";
    repeat (500) begin
      stall_en = 1'($urandom % 2);
      repeat ($urandom % 4) next_slot();  // idle gap
      if ($urandom % 3 == 0) begin
        // aw and ar raised together, distinct words so order cannot matter
        wa = pick_addr();
        ra = pick_addr();
        while (ra == wa) ra = rand_word_addr();
        wd = $urandom;
        ws = bram_pkg::axil_strb_t'($urandom % 16);
        fork
          write_and_check(wa, wd, ws);
          read_and_check(ra);
        join
      end else begin
        random_op();
      end
    end
    stall_en = 1'b0;
    foreach (used_addr[i]) read_and_check(used_addr[i]);

    $display("Done: no errors");
    $finish;
  end

endmodule

//--- filelist.f
hdl/bram_pkg.sv
hdl/bram_if.sv
hdl/axil_bram_ctrl.sv
hdl/bank_xlate.sv
hdl/bram_bank.sv
hdl/banked_mem_top.sv
dv/tb_banked_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module tb_banked_mem -Mdir obj_dir > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_banked_mem > sim.log 2>&1 || true
cat sim.log
grep -qx "Done: no errors" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }
